// File: hdl/commit_pkg.sv
// sizes, unit indices and the warp helper shared by the commit stage, referenced by scoped names
package commit_pkg;

    localparam int ISSUE_WIDTH   = 2;
    localparam int NUM_EX_UNITS  = 3;
    localparam int NUM_WARPS     = 4;
    localparam int NW_WIDTH      = $clog2(NUM_WARPS);
    localparam int NUM_THREADS   = 4;
    localparam int XLEN          = 32;
    localparam int NR_BITS       = 5;
    localparam int PERF_CTR_BITS = 32;

    // active-thread count of one slot, and the sum of those counts over all slots
    localparam int COMMIT_SIZEW     = $clog2(NUM_THREADS + 1);
    localparam int COMMIT_ALL_SIZEW = COMMIT_SIZEW + ISSUE_WIDTH - 1;

    // warps are interleaved over the slots, so each slot owns NUM_WARPS / ISSUE_WIDTH of them
    localparam int WIS_WIDTH = $clog2(NUM_WARPS / ISSUE_WIDTH);

    // packed commit payload holds wid, pc, tmask, rd, wb, data, sop and eop in that order
    localparam int COMMIT_DATAW = NW_WIDTH + XLEN + NUM_THREADS + NR_BITS + 1
                                + NUM_THREADS * XLEN + 2;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_unit_e;

    // index of a warp within the slot that issues it
    function automatic logic [WIS_WIDTH-1:0] wid_to_wis(input logic [NW_WIDTH-1:0] wid);
        return WIS_WIDTH'(wid / ISSUE_WIDTH);
    endfunction

endpackage

// File: hdl/commit_if.sv
// commit stream from an execution unit or a slot arbiter, one result per valid/ready transfer
interface commit_if;

    logic                                                        valid;
    logic                                                        ready;
    logic [commit_pkg::NW_WIDTH-1:0]                             wid;
    logic [commit_pkg::XLEN-1:0]                                 pc;
    logic [commit_pkg::NUM_THREADS-1:0]                          tmask;
    logic [commit_pkg::NR_BITS-1:0]                              rd;
    logic                                                        wb;
    logic [commit_pkg::NUM_THREADS-1:0][commit_pkg::XLEN-1:0]    data;
    // sop and eop mark the first and last beat of a multi-beat result
    logic                                                        sop;
    logic                                                        eop;

    modport master (
        output valid, wid, pc, tmask, rd, wb, data, sop, eop,
        input  ready
    );

    modport slave (
        input  valid, wid, pc, tmask, rd, wb, data, sop, eop,
        output ready
    );

endinterface

// File: hdl/writeback_if.sv
// register-file writeback strobe of one issue slot, each valid cycle is one register write
interface writeback_if;

    logic                                                        valid;
    logic [commit_pkg::WIS_WIDTH-1:0]                            wis;
    logic [commit_pkg::XLEN-1:0]                                 pc;
    logic [commit_pkg::NUM_THREADS-1:0]                          tmask;
    logic [commit_pkg::NR_BITS-1:0]                              rd;
    logic [commit_pkg::NUM_THREADS-1:0][commit_pkg::XLEN-1:0]    data;
    logic                                                        sop;
    logic                                                        eop;

    modport master (output valid, wis, pc, tmask, rd, data, sop, eop);

    modport slave (input valid, wis, pc, tmask, rd, data, sop, eop);

endinterface

// File: hdl/commit_arb.sv
// round-robin arbiter of one issue slot, grants one unit per cycle into a registered output strobe
module commit_arb (
    input  logic                 clk,
    input  logic                 reset,
    commit_if.slave              in_if [commit_pkg::NUM_EX_UNITS],
    commit_if.master             out_if,
    output commit_pkg::ex_unit_e sel
);

    logic [commit_pkg::NUM_EX_UNITS-1:0]                               in_valid;
    logic [commit_pkg::NUM_EX_UNITS-1:0]                               in_ready;
    logic [commit_pkg::NUM_EX_UNITS-1:0][commit_pkg::COMMIT_DATAW-1:0] in_data;
    logic [commit_pkg::COMMIT_DATAW-1:0]                               out_data_r;
    logic                                                              out_valid_r;
    logic                                                              grant_found;
    commit_pkg::ex_unit_e                                              grant_idx;
    commit_pkg::ex_unit_e                                              ptr;

    for (genvar u = 0; u < commit_pkg::NUM_EX_UNITS; u++) begin : g_in
        assign in_valid[u] = in_if[u].valid;
        assign in_data[u]  = {in_if[u].wid, in_if[u].pc, in_if[u].tmask, in_if[u].rd,
                              in_if[u].wb, in_if[u].data, in_if[u].sop, in_if[u].eop};
        assign in_if[u].ready = in_ready[u];
    end

    // search upward from the pointer and wrap, the unit served last ends up with lowest priority
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = ptr;
        in_ready    = '0;
        for (int k = 0; k < commit_pkg::NUM_EX_UNITS; k++) begin
            idx = (int'(ptr) + k) % commit_pkg::NUM_EX_UNITS;
            if (!grant_found && in_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = commit_pkg::ex_unit_e'(idx);
            end
        end
        if (grant_found) begin
            in_ready[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_r <= 1'b0;
            ptr         <= commit_pkg::EX_ALU;
        end else begin
            out_valid_r <= grant_found;
            if (grant_found) begin
                ptr <= commit_pkg::ex_unit_e'((int'(grant_idx) + 1) % commit_pkg::NUM_EX_UNITS);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_found) begin
            out_data_r <= in_data[grant_idx];
            sel        <= grant_idx;
        end
    end

    // the output is a one-cycle strobe, its consumer never stalls
    assign out_if.valid = out_valid_r;
    assign {out_if.wid, out_if.pc, out_if.tmask, out_if.rd,
            out_if.wb, out_if.data, out_if.sop, out_if.eop} = out_data_r;

    a_one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(in_ready));

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
        (in_ready & ~in_valid) == '0);

endmodule

// File: hdl/instret_counter.sv
// retired thread-instruction counter, popcount then reduction then accumulate over three cycles
module instret_counter (
    input  logic                                                          clk,
    input  logic                                                          reset,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0]                            fire,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_THREADS-1:0] tmask,
    output logic [commit_pkg::PERF_CTR_BITS-1:0]                          instret
);

    logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::COMMIT_SIZEW-1:0] size;
    logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::COMMIT_SIZEW-1:0] size_r;
    logic [commit_pkg::COMMIT_ALL_SIZEW-1:0]                          sum;
    logic [commit_pkg::COMMIT_ALL_SIZEW-1:0]                          sum_rr;
    logic                                                             fire_any_r;
    logic                                                             fire_any_rr;

    // threads that retire in each slot this cycle
    always_comb begin
        int cnt;
        for (int i = 0; i < commit_pkg::ISSUE_WIDTH; i++) begin
            cnt     = $countones(tmask[i] & {commit_pkg::NUM_THREADS{fire[i]}});
            size[i] = cnt[commit_pkg::COMMIT_SIZEW-1:0];
        end
    end

    always_comb begin
        int total;
        total = 0;
        for (int i = 0; i < commit_pkg::ISSUE_WIDTH; i++) begin
            total = total + int'(size_r[i]);
        end
        sum = total[commit_pkg::COMMIT_ALL_SIZEW-1:0];
    end

    always_ff @(posedge clk) begin
        size_r <= size;
        sum_rr <= sum;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fire_any_r  <= 1'b0;
            fire_any_rr <= 1'b0;
            instret     <= '0;
        end else begin
            fire_any_r  <= |fire;
            fire_any_rr <= fire_any_r;
            if (fire_any_rr) begin
                instret <= instret + {{(commit_pkg::PERF_CTR_BITS
                                        - commit_pkg::COMMIT_ALL_SIZEW){1'b0}}, sum_rr};
            end
        end
    end

    a_sum_bound: assert property (@(posedge clk) disable iff (reset)
        fire_any_rr |-> int'(sum_rr) <= commit_pkg::ISSUE_WIDTH * commit_pkg::NUM_THREADS);

endmodule

// File: hdl/commit_stage.sv
// commit stage, arbitrates unit results per slot and drives writeback, scheduler and instret
module commit_stage (
    input  logic                                                       clk,
    input  logic                                                       reset,
    commit_if.slave                                                    alu_if [commit_pkg::ISSUE_WIDTH],
    commit_if.slave                                                    lsu_if [commit_pkg::ISSUE_WIDTH],
    commit_if.slave                                                    sfu_if [commit_pkg::ISSUE_WIDTH],
    writeback_if.master                                                wb_if [commit_pkg::ISSUE_WIDTH],
    output logic [commit_pkg::ISSUE_WIDTH-1:0]                         committed,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NW_WIDTH-1:0] committed_wid,
    output logic [commit_pkg::PERF_CTR_BITS-1:0]                       instret
);

    logic [commit_pkg::ISSUE_WIDTH-1:0]                          commit_fire;
    logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_THREADS-1:0] commit_tmask;

    for (genvar i = 0; i < commit_pkg::ISSUE_WIDTH; i++) begin : g_slot
        commit_if                                                          arb_in [commit_pkg::NUM_EX_UNITS] ();
        commit_if                                                          arb_out ();
        logic [commit_pkg::NUM_EX_UNITS-1:0]                               src_valid;
        logic [commit_pkg::NUM_EX_UNITS-1:0][commit_pkg::COMMIT_DATAW-1:0] src_data;

        // gather the three units of this slot into the arbiter's input order
        assign src_valid[commit_pkg::EX_ALU] = alu_if[i].valid;
        assign src_valid[commit_pkg::EX_LSU] = lsu_if[i].valid;
        assign src_valid[commit_pkg::EX_SFU] = sfu_if[i].valid;
        assign src_data[commit_pkg::EX_ALU] = {alu_if[i].wid, alu_if[i].pc, alu_if[i].tmask,
            alu_if[i].rd, alu_if[i].wb, alu_if[i].data, alu_if[i].sop, alu_if[i].eop};
        assign src_data[commit_pkg::EX_LSU] = {lsu_if[i].wid, lsu_if[i].pc, lsu_if[i].tmask,
            lsu_if[i].rd, lsu_if[i].wb, lsu_if[i].data, lsu_if[i].sop, lsu_if[i].eop};
        assign src_data[commit_pkg::EX_SFU] = {sfu_if[i].wid, sfu_if[i].pc, sfu_if[i].tmask,
            sfu_if[i].rd, sfu_if[i].wb, sfu_if[i].data, sfu_if[i].sop, sfu_if[i].eop};
        assign alu_if[i].ready = arb_in[commit_pkg::EX_ALU].ready;
        assign lsu_if[i].ready = arb_in[commit_pkg::EX_LSU].ready;
        assign sfu_if[i].ready = arb_in[commit_pkg::EX_SFU].ready;

        for (genvar u = 0; u < commit_pkg::NUM_EX_UNITS; u++) begin : g_unit
            assign arb_in[u].valid = src_valid[u];
            assign {arb_in[u].wid, arb_in[u].pc, arb_in[u].tmask, arb_in[u].rd,
                    arb_in[u].wb, arb_in[u].data, arb_in[u].sop, arb_in[u].eop} = src_data[u];
        end

        commit_arb commit_arb_inst (
            .clk    (clk),
            .reset  (reset),
            .in_if  (arb_in),
            .out_if (arb_out),
            .sel    ()
        );

        // writeback has no back-pressure, every output strobe is one register write
        assign wb_if[i].valid = arb_out.valid && arb_out.wb;
        assign wb_if[i].wis   = commit_pkg::wid_to_wis(arb_out.wid);
        assign wb_if[i].pc    = arb_out.pc;
        assign wb_if[i].tmask = arb_out.tmask;
        assign wb_if[i].rd    = arb_out.rd;
        assign wb_if[i].data  = arb_out.data;
        assign wb_if[i].sop   = arb_out.sop;
        assign wb_if[i].eop   = arb_out.eop;

        assign commit_fire[i]  = arb_out.valid;
        assign commit_tmask[i] = arb_out.tmask;

        // the scheduler only hears about the last beat of an instruction
        always_ff @(posedge clk) begin
            if (reset) begin
                committed[i] <= 1'b0;
            end else begin
                committed[i] <= arb_out.valid && arb_out.eop;
            end
        end

        always_ff @(posedge clk) begin
            committed_wid[i] <= arb_out.wid;
        end
    end

    instret_counter instret_counter_inst (
        .clk     (clk),
        .reset   (reset),
        .fire    (commit_fire),
        .tmask   (commit_tmask),
        .instret (instret)
    );

endmodule

// File: hdl/commit_top.sv
// top level of the commit stage, wraps slot-by-unit plain ports into stream interfaces
module commit_top (
    input  logic                                                            clk,
    input  logic                                                            reset,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0] ex_valid,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0] ex_ready,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0]
                 [commit_pkg::NW_WIDTH-1:0]                                 ex_wid,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0]
                 [commit_pkg::XLEN-1:0]                                     ex_pc,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0]
                 [commit_pkg::NUM_THREADS-1:0]                              ex_tmask,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0]
                 [commit_pkg::NR_BITS-1:0]                                  ex_rd,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0] ex_wb,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0]
                 [commit_pkg::NUM_THREADS-1:0][commit_pkg::XLEN-1:0]        ex_data,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0] ex_sop,
    input  logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_EX_UNITS-1:0] ex_eop,
    output logic [commit_pkg::ISSUE_WIDTH-1:0]                              wb_valid,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::WIS_WIDTH-1:0]   wb_wis,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::XLEN-1:0]        wb_pc,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_THREADS-1:0] wb_tmask,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NR_BITS-1:0]     wb_rd,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NUM_THREADS-1:0]
                 [commit_pkg::XLEN-1:0]                                     wb_data,
    output logic [commit_pkg::ISSUE_WIDTH-1:0]                              wb_sop,
    output logic [commit_pkg::ISSUE_WIDTH-1:0]                              wb_eop,
    output logic [commit_pkg::ISSUE_WIDTH-1:0]                              committed,
    output logic [commit_pkg::ISSUE_WIDTH-1:0][commit_pkg::NW_WIDTH-1:0]    committed_wid,
    output logic [commit_pkg::PERF_CTR_BITS-1:0]                            instret
);

    commit_if    alu_if [commit_pkg::ISSUE_WIDTH] ();
    commit_if    lsu_if [commit_pkg::ISSUE_WIDTH] ();
    commit_if    sfu_if [commit_pkg::ISSUE_WIDTH] ();
    writeback_if wb_if [commit_pkg::ISSUE_WIDTH] ();

    for (genvar i = 0; i < commit_pkg::ISSUE_WIDTH; i++) begin : g_slot
        logic [commit_pkg::NUM_EX_UNITS-1:0][commit_pkg::COMMIT_DATAW-1:0] ex_payload;

        for (genvar u = 0; u < commit_pkg::NUM_EX_UNITS; u++) begin : g_unit
            assign ex_payload[u] = {ex_wid[i][u], ex_pc[i][u], ex_tmask[i][u], ex_rd[i][u],
                                    ex_wb[i][u], ex_data[i][u], ex_sop[i][u], ex_eop[i][u]};
        end

        assign alu_if[i].valid = ex_valid[i][commit_pkg::EX_ALU];
        assign lsu_if[i].valid = ex_valid[i][commit_pkg::EX_LSU];
        assign sfu_if[i].valid = ex_valid[i][commit_pkg::EX_SFU];
        assign {alu_if[i].wid, alu_if[i].pc, alu_if[i].tmask, alu_if[i].rd, alu_if[i].wb,
                alu_if[i].data, alu_if[i].sop, alu_if[i].eop} = ex_payload[commit_pkg::EX_ALU];
        assign {lsu_if[i].wid, lsu_if[i].pc, lsu_if[i].tmask, lsu_if[i].rd, lsu_if[i].wb,
                lsu_if[i].data, lsu_if[i].sop, lsu_if[i].eop} = ex_payload[commit_pkg::EX_LSU];
        assign {sfu_if[i].wid, sfu_if[i].pc, sfu_if[i].tmask, sfu_if[i].rd, sfu_if[i].wb,
                sfu_if[i].data, sfu_if[i].sop, sfu_if[i].eop} = ex_payload[commit_pkg::EX_SFU];
        assign ex_ready[i][commit_pkg::EX_ALU] = alu_if[i].ready;
        assign ex_ready[i][commit_pkg::EX_LSU] = lsu_if[i].ready;
        assign ex_ready[i][commit_pkg::EX_SFU] = sfu_if[i].ready;

        assign wb_valid[i] = wb_if[i].valid;
        assign wb_wis[i]   = wb_if[i].wis;
        assign wb_pc[i]    = wb_if[i].pc;
        assign wb_tmask[i] = wb_if[i].tmask;
        assign wb_rd[i]    = wb_if[i].rd;
        assign wb_data[i]  = wb_if[i].data;
        assign wb_sop[i]   = wb_if[i].sop;
        assign wb_eop[i]   = wb_if[i].eop;
    end

    commit_stage commit_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .alu_if        (alu_if),
        .lsu_if        (lsu_if),
        .sfu_if        (sfu_if),
        .wb_if         (wb_if),
        .committed     (committed),
        .committed_wid (committed_wid),
        .instret       (instret)
    );

endmodule

// File: testbench/tb_commit.sv
// testbench for the commit stage, applies a table of unit results and checks writeback, committed and instret
module tb_commit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NS = commit_pkg::ISSUE_WIDTH;
    localparam int NU = commit_pkg::NUM_EX_UNITS;
    localparam int NT = commit_pkg::NUM_THREADS;
    localparam int NROWS = 12;
    localparam int MAX_CYCLES = 20 * NROWS + 100;

    typedef struct packed {
        int         start;
        logic       slot;
        logic [1:0] unit;
        logic [1:0] wid;
        logic [3:0] tmask;
        logic [4:0] rd;
        logic       wb;
        logic       sop;
        logic       eop;
    } row_t;

    // unit 0 is ALU, 1 is LSU, 2 is SFU
    row_t rows [NROWS] = '{
        // start slot  unit  wid   tmask    rd     wb    sop   eop
        '{0,  1'b0, 2'd0, 2'd0, 4'b1111, 5'd1,  1'b1, 1'b1, 1'b1},
        '{0,  1'b0, 2'd1, 2'd2, 4'b0101, 5'd2,  1'b1, 1'b1, 1'b0},
        '{0,  1'b0, 2'd2, 2'd0, 4'b0011, 5'd3,  1'b1, 1'b1, 1'b1},
        '{0,  1'b1, 2'd1, 2'd1, 4'b1000, 5'd4,  1'b1, 1'b1, 1'b1},
        '{2,  1'b1, 2'd0, 2'd3, 4'b0110, 5'd5,  1'b0, 1'b1, 1'b1},
        '{3,  1'b0, 2'd1, 2'd2, 4'b1010, 5'd2,  1'b1, 1'b0, 1'b1},
        '{6,  1'b1, 2'd2, 2'd1, 4'b1111, 5'd6,  1'b1, 1'b1, 1'b1},
        '{6,  1'b1, 2'd0, 2'd3, 4'b0001, 5'd7,  1'b1, 1'b1, 1'b0},
        '{6,  1'b1, 2'd1, 2'd1, 4'b1110, 5'd8,  1'b0, 1'b1, 1'b1},
        '{10, 1'b0, 2'd2, 2'd2, 4'b0111, 5'd9,  1'b1, 1'b1, 1'b1},
        '{10, 1'b0, 2'd0, 2'd0, 4'b1001, 5'd10, 1'b1, 1'b1, 1'b1},
        '{12, 1'b1, 2'd0, 2'd3, 4'b1100, 5'd11, 1'b1, 1'b0, 1'b1}
    };

    logic clk = 1'b0;
    logic reset;
    logic [NS-1:0][NU-1:0] ex_valid, ex_ready, ex_wb, ex_sop, ex_eop;
    logic [NS-1:0][NU-1:0][commit_pkg::NW_WIDTH-1:0] ex_wid;
    logic [NS-1:0][NU-1:0][commit_pkg::XLEN-1:0] ex_pc;
    logic [NS-1:0][NU-1:0][NT-1:0] ex_tmask;
    logic [NS-1:0][NU-1:0][commit_pkg::NR_BITS-1:0] ex_rd;
    logic [NS-1:0][NU-1:0][NT-1:0][commit_pkg::XLEN-1:0] ex_data;
    logic [NS-1:0] wb_valid, wb_sop, wb_eop, committed;
    logic [NS-1:0][commit_pkg::WIS_WIDTH-1:0] wb_wis;
    logic [NS-1:0][commit_pkg::XLEN-1:0] wb_pc;
    logic [NS-1:0][NT-1:0] wb_tmask;
    logic [NS-1:0][commit_pkg::NR_BITS-1:0] wb_rd;
    logic [NS-1:0][NT-1:0][commit_pkg::XLEN-1:0] wb_data;
    logic [NS-1:0][commit_pkg::NW_WIDTH-1:0] committed_wid;
    logic [commit_pkg::PERF_CTR_BITS-1:0] instret;

    logic [NT-1:0][31:0] row_data [NROWS];
    logic [31:0]         lcg_state;
    bit                  started [NROWS];
    int                  active [NS][NU];
    bit                  fired [NS][NU];
    int                  acc_q [NS][$];
    int                  rr_ptr [NS];
    logic                exp_comm [NS];
    logic [1:0]          exp_comm_wid [NS];
    int unsigned         run_sum, hist1, hist2, hist3;
    int                  errors, accepted, cyc, idle_cycles;
    bit                  timed_out;

    commit_top commit_top_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_field(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    function automatic bit work_left();
        bit busy;
        busy = 1'b0;
        for (int r = 0; r < NROWS; r++) begin
            if (!started[r]) busy = 1'b1;
        end
        for (int s = 0; s < NS; s++) begin
            if (acc_q[s].size() != 0) busy = 1'b1;
            for (int u = 0; u < NU; u++) begin
                if (active[s][u] >= 0) busy = 1'b1;
            end
        end
        return busy;
    endfunction

    // outputs are stable here, the last posedge was half a period ago
    task automatic check_outputs();
        int r;
        hist3 = hist2;
        hist2 = hist1;
        hist1 = run_sum;
        check_field("instret", instret, hist3);
        for (int s = 0; s < NS; s++) begin
            check_field($sformatf("committed[%0d]", s), committed[s], exp_comm[s]);
            if (exp_comm[s]) begin
                check_field($sformatf("committed_wid[%0d]", s), committed_wid[s], exp_comm_wid[s]);
            end
            exp_comm[s] = 1'b0;
            if (acc_q[s].size() == 0) begin
                check_field($sformatf("wb_valid[%0d]", s), wb_valid[s], 1'b0);
            end else begin
                r = acc_q[s].pop_front();
                run_sum += $countones(rows[r].tmask);
                exp_comm[s] = rows[r].eop;
                exp_comm_wid[s] = rows[r].wid;
                check_field($sformatf("wb_valid[%0d]", s), wb_valid[s], rows[r].wb);
                if (rows[r].wb) begin
                    check_field($sformatf("wb_wis[%0d]", s), wb_wis[s], rows[r].wid / 2);
                    check_field($sformatf("wb_pc[%0d]", s), wb_pc[s], 32'h1000 + 32'(r * 4));
                    check_field($sformatf("wb_tmask[%0d]", s), wb_tmask[s], rows[r].tmask);
                    check_field($sformatf("wb_rd[%0d]", s), wb_rd[s], rows[r].rd);
                    check_field($sformatf("wb_data[%0d]", s), wb_data[s], row_data[r]);
                    check_field($sformatf("wb_sop[%0d]", s), wb_sop[s], rows[r].sop);
                    check_field($sformatf("wb_eop[%0d]", s), wb_eop[s], rows[r].eop);
                end
            end
        end
    endtask

    // drop the rows that transferred at the last edge, then raise the rows that are due
    task automatic load_rows();
        int s;
        int u;
        for (int i = 0; i < NS; i++) begin
            for (int j = 0; j < NU; j++) begin
                if (fired[i][j]) begin
                    fired[i][j] = 1'b0;
                    active[i][j] = -1;
                    ex_valid[i][j] = 1'b0;
                end
            end
        end
        for (int r = 0; r < NROWS; r++) begin
            s = int'(rows[r].slot);
            u = int'(rows[r].unit);
            if (!started[r] && rows[r].start <= cyc && active[s][u] < 0) begin
                started[r] = 1'b1;
                active[s][u] = r;
                ex_valid[s][u] = 1'b1;
                ex_wid[s][u] = rows[r].wid;
                ex_pc[s][u] = 32'h1000 + 32'(r * 4);
                ex_tmask[s][u] = rows[r].tmask;
                ex_rd[s][u] = rows[r].rd;
                ex_wb[s][u] = rows[r].wb;
                ex_data[s][u] = row_data[r];
                ex_sop[s][u] = rows[r].sop;
                ex_eop[s][u] = rows[r].eop;
            end
        end
    endtask

    // the model grants from its own round-robin pointer and compares with the DUT's ready
    task automatic sample_handshakes();
        logic [NU-1:0] exp_ready;
        int u;
        int g;
        for (int s = 0; s < NS; s++) begin
            exp_ready = '0;
            g = -1;
            for (int k = 0; k < NU; k++) begin
                u = (rr_ptr[s] + k) % NU;
                if (g < 0 && ex_valid[s][u]) g = u;
            end
            if (g >= 0) begin
                exp_ready[g] = 1'b1;
                rr_ptr[s] = (g + 1) % NU;
            end
            check_field($sformatf("ex_ready[%0d]", s), ex_ready[s], exp_ready);
            for (int j = 0; j < NU; j++) begin
                if (ex_valid[s][j] && ex_ready[s][j]) begin
                    acc_q[s].push_back(active[s][j]);
                    fired[s][j] = 1'b1;
                    accepted++;
                end
            end
        end
    endtask

    initial begin
        int total;
        reset = 1'b1;
        ex_valid = '0;
        ex_wid = '0;
        ex_pc = '0;
        ex_tmask = '0;
        ex_rd = '0;
        ex_wb = '0;
        ex_data = '0;
        ex_sop = '0;
        ex_eop = '0;
        lcg_state = 32'd72778;
        for (int r = 0; r < NROWS; r++) begin
            for (int t = 0; t < NT; t++) begin
                lcg_state = lcg_next(lcg_state);
                row_data[r][t] = lcg_state;
            end
        end
        for (int s = 0; s < NS; s++) begin
            rr_ptr[s] = 0;
            exp_comm[s] = 1'b0;
            for (int u = 0; u < NU; u++) begin
                active[s][u] = -1;
            end
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_field("wb_valid", wb_valid, '0);
        check_field("committed", committed, '0);
        check_field("ex_ready", ex_ready, '0);
        check_field("instret", instret, '0);

        while (1) begin
            check_outputs();
            if (work_left()) idle_cycles = 0;
            else idle_cycles++;
            // a few idle cycles let committed and the instret pipeline settle
            if (idle_cycles > 5) break;
            if (cyc >= MAX_CYCLES) begin
                timed_out = 1'b1;
                $display("timeout: the table did not drain within %0d cycles", MAX_CYCLES);
                break;
            end
            load_rows();
            #1;
            sample_handshakes();
            cyc++;
            @(negedge clk);
        end

        total = 0;
        for (int r = 0; r < NROWS; r++) begin
            total += $countones(rows[r].tmask);
        end
        if (!timed_out) begin
            check_field("instret", instret, total);
            check_field("accepted rows", accepted, NROWS);
        end
        $display("checks done: %0d errors, %0d timeouts, %0d of %0d rows accepted",
                 errors, timed_out, accepted, NROWS);
        if (errors == 0 && !timed_out) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/commit_pkg.sv
hdl/commit_if.sv
hdl/writeback_if.sv
hdl/commit_arb.sv
hdl/instret_counter.sv
hdl/commit_stage.sv
hdl/commit_top.sv
testbench/tb_commit.sv

// File: run_sim.sh
#!/bin/sh
# builds the commit stage testbench with Verilator, runs it and searches its output for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_commit -o tb_commit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_commit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
